// File: bench/pe_tb.sv
`include "pe_defs.svh"

module pe_tb;
    import pe_pkg::*;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`PE_WB_AW-1:0] adr;
    logic [31:0]          dat_w;
    logic [31:0]          dat_r;
    logic                 ack;
    logic                 ifm_valid;
    logic                 ifm_ready;
    in_word_t             ifm_word;
    logic                 filt_valid;
    logic                 filt_ready;
    in_word_t             filt_word;
    logic                 psum_valid;
    logic                 psum_ready;
    acc_t                 psum_data;

    // Current trace test
    int    flen;
    int    strd;
    int    exp_windows;
    int    nf;
    int    ni;
    data_t filt_words [`PE_FILT_DEPTH];
    data_t if_words [`PE_IF_DEPTH];
    acc_t  exp_sums [`PE_IF_DEPTH];

    int          fd;
    int          errors;
    int          checks;
    int          cycles = 0;
    int          cycle_limit = 2000;
    logic [31:0] rng = 32'h5278;

    pe_top i_pe_top (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .ifm_valid  (ifm_valid),
        .ifm_ready  (ifm_ready),
        .ifm_word   (ifm_word),
        .filt_valid (filt_valid),
        .filt_ready (filt_ready),
        .filt_word  (filt_word),
        .psum_valid (psum_valid),
        .psum_ready (psum_ready),
        .psum_data  (psum_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic read_token(output logic [31:0] val, output bit ok);
        string tok;
        string rest;
        int    n;
        bit    eof;
        ok = 1'b0;
        eof = 1'b0;
        val = 32'h0;
        while (!ok && !eof) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                eof = 1'b1;
            end else if (tok.substr(0, 0) == "#") begin
                // Skip the rest of a comment line
                n = $fgets(rest, fd);
            end else begin
                n = $sscanf(tok, "%h", val);
                ok = (n == 1);
                eof = !ok;
            end
        end
    endtask

    // 0 at end of file, 1 for a test, 2 for a malformed test
    task automatic load_test(output int result);
        logic [31:0] hdr [5];
        logic [31:0] v;
        bit          ok;
        bit          all_ok;
        read_token(hdr[0], ok);
        result = 0;
        if (ok) begin
            all_ok = 1'b1;
            for (int i = 1; i < 5; i++) begin
                read_token(hdr[i], ok);
                all_ok = all_ok & ok;
            end
            flen = int'(hdr[0]);
            strd = int'(hdr[1]);
            exp_windows = int'(hdr[2]);
            nf = int'(hdr[3]);
            ni = int'(hdr[4]);
            if (nf < 1 || nf > `PE_FILT_DEPTH || ni < 1 || ni > `PE_IF_DEPTH || strd < 1)
                all_ok = 1'b0;
            for (int i = 0; i < nf && all_ok; i++) begin
                read_token(v, ok);
                all_ok = all_ok & ok;
                filt_words[i] = v[`PE_DATA_W-1:0];
            end
            for (int i = 0; i < ni && all_ok; i++) begin
                read_token(v, ok);
                all_ok = all_ok & ok;
                if_words[i] = v[`PE_DATA_W-1:0];
            end
            result = all_ok ? 1 : 2;
        end
    endtask

    // Window j, tap k pairs ifmap j*stride+k with filter k
    task automatic model_sums(output int n);
        int acc;
        n = (flen > ni) ? 0 : (ni - flen) / strd + 1;
        for (int j = 0; j < n; j++) begin
            acc = 0;
            for (int k = 0; k < flen; k++)
                acc = acc + int'(if_words[j * strd + k]) * int'(filt_words[k]);
            exp_sums[j] = acc[`PE_ACC_W-1:0];
        end
    endtask

    task automatic write_reg(input logic [`PE_WB_AW-1:0] a, input logic [31:0] d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = a;
        dat_w = d;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic read_reg(input logic [`PE_WB_AW-1:0] a, output logic [31:0] d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        d = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic run_test(input int num);
        int          n_win;
        int          ip;
        int          fp;
        int          np;
        int          poke;
        int          errs_before;
        logic [31:0] r;
        logic [31:0] status;
        errs_before = errors;
        model_sums(n_win);
        compare("window count", 32'(n_win), 32'(exp_windows));
        write_reg(`PE_REG_FILT_LEN, 32'(flen));
        write_reg(`PE_REG_STRIDE, 32'(strd));
        write_reg(`PE_REG_CTRL, 32'h1);
        // Done of the previous run must be gone now
        read_reg(`PE_REG_STATUS, status);
        compare("status busy", status & 32'h1, 32'h1);
        compare("status done", (status >> 1) & 32'h1, 32'h0);
        ip = 0;
        fp = 0;
        np = 0;
        poke = 0;
        while (ip < ni || fp < nf || np < n_win || poke == 1) begin
            @(negedge clk);
            r = xorshift();
            ifm_valid = (ip < ni) && (r[1:0] != 2'd0);
            if (ip < ni) begin
                ifm_word.data = if_words[ip];
                ifm_word.last = (ip == ni - 1);
            end
            filt_valid = (fp < nf) && (r[3:2] != 2'd0);
            if (fp < nf) begin
                filt_word.data = filt_words[fp];
                filt_word.last = (fp == nf - 1);
            end
            psum_ready = (r[5:4] != 2'd0);
            // A start written mid-run must be ignored
            if (poke == 0 && np >= 1) begin
                cyc = 1'b1;
                stb = 1'b1;
                we = 1'b1;
                adr = `PE_REG_CTRL;
                dat_w = 32'h1;
                poke = 1;
            end else if (poke == 1 && ack) begin
                cyc = 1'b0;
                stb = 1'b0;
                we = 1'b0;
                poke = 2;
            end
            // Transfers happen on the coming rising edge
            if (ifm_valid && ifm_ready)
                ip++;
            if (filt_valid && filt_ready)
                fp++;
            if (psum_valid && psum_ready) begin
                if (np < n_win) begin
                    compare("psum_data", 32'(psum_data), 32'(exp_sums[np]));
                end else begin
                    errors++;
                    $display("Test %0d produced more partial sums than expected", num);
                end
                np++;
            end
        end
        @(negedge clk);
        ifm_valid = 1'b0;
        filt_valid = 1'b0;
        psum_ready = 1'b1;
        // Both streams close after their last word
        compare("ifm_ready", 32'(ifm_ready), 32'h0);
        compare("filt_ready", 32'(filt_ready), 32'h0);
        status = 32'h0;
        while (!status[1])
            read_reg(`PE_REG_STATUS, status);
        compare("status busy", status & 32'h1, 32'h0);
        compare("status count", (status >> 8) & 32'hff, 32'(n_win));
        $display("Test %0d: filt_len %0d stride %0d ifmap %0d windows %0d, %0d errors",
                 num, flen, strd, ni, n_win, errors - errs_before);
    endtask

    initial begin
        logic [31:0] status;
        logic [31:0] value;
        int          result;
        int          ntests;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = 32'h0;
        ifm_valid = 1'b0;
        ifm_word = '0;
        filt_valid = 1'b0;
        filt_word = '0;
        psum_ready = 1'b0;
        errors = 0;
        checks = 0;
        ntests = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Stream handshakes are quiet after reset
        compare("ifm_ready", 32'(ifm_ready), 32'h0);
        compare("filt_ready", 32'(filt_ready), 32'h0);
        compare("psum_valid", 32'(psum_valid), 32'h0);

        // Idle status and register read back
        read_reg(`PE_REG_STATUS, status);
        compare("status", status, 32'h0);
        write_reg(`PE_REG_FILT_LEN, 32'h5);
        read_reg(`PE_REG_FILT_LEN, value);
        compare("filt_len", value, 32'h5);
        write_reg(`PE_REG_STRIDE, 32'h1b);
        read_reg(`PE_REG_STRIDE, value);
        compare("stride", value, 32'h1b);
        $display("Register test: %0d errors", errors);

        fd = $fopen("bench/pe_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/pe_trace.txt");
            errors++;
        end else begin
            result = 1;
            while (result == 1) begin
                load_test(result);
                if (result == 1) begin
                    ntests++;
                    cycle_limit = cycle_limit + 2000;
                    run_test(ntests);
                end else if (result == 2) begin
                    $display("Trace file has a malformed test after test %0d", ntests);
                    errors++;
                end
            end
            $fclose(fd);
            if (ntests == 0) begin
                $display("No tests were found in the trace file");
                errors++;
            end
        end

        $display("Tests %0d, checks %0d, errors %0d", ntests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: bench/pe_trace.txt
# Columns: filt_len stride windows n_filt n_ifmap, all hex
# Then n_filt filter words and n_ifmap ifmap words, signed 8-bit hex
# Unit stride, filter length 3
3 1 6 3 8
01 02 03
01 02 03 04 05 06 07 08
# Stride 2, last window ends short of the row
3 2 4 3 a
ff 02 01
10 20 30 40 50 60 70 80 90 a0
# Stride 3 with filter length 2
2 3 3 2 a
05 fb
01 02 03 04 05 06 07 08 09 0a
# Filter length 1
1 1 5 1 5
fd
7f 80 00 01 ff
# Filter as long as the row
4 1 1 4 4
01 ff 01 ff
11 22 33 44
# Filter longer than the row, no windows
5 1 0 5 3
01 01 01 01 01
01 01 01
# Extreme values over the full filter depth
8 1 3 8 a
80 80 80 80 80 80 80 80
80 7f 80 7f 80 80 80 80 7f 80
# Full ifmap depth, stride 3
8 3 9 8 20
01 fe 03 fc 05 fa 07 f8
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff
# Stride 5
3 5 3 3 10
7f 7f 7f
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
# Mixed signs, stride 2
4 2 3 4 9
fe 03 81 7f
c0 40 e0 20 f0 10 f8 08 fc
# Filter stream longer than the configured length
2 1 5 4 6
03 04 7f 7f
01 02 03 04 05 06

// File: design/mac_pipeline.sv
module mac_pipeline (
    input  logic          clk,
    input  logic          rst,
    input  logic          tap_valid,
    input  pe_pkg::tap_t  tap,
    input  pe_pkg::data_t if_data,
    input  pe_pkg::data_t filt_data,
    output logic          psum_valid,
    input  logic          psum_ready,
    output pe_pkg::acc_t  psum_data,
    output logic          stall,
    output logic          out_fire,
    output logic          out_drained
);
    import pe_pkg::*;

    logic s1_valid;
    logic s1_first;
    logic s1_last;
    logic s2_valid;
    logic s2_first;
    logic s2_last;
    acc_t prod;
    acc_t acc;
    acc_t sum_next;

    // Held output blocks every stage, including the scratch read
    assign stall       = psum_valid & ~psum_ready;
    assign out_fire    = psum_valid & psum_ready;
    assign out_drained = ~s1_valid & ~s2_valid & ~psum_valid;

    // First tap restarts the sum
    assign sum_next = s2_first ? prod : acc + prod;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            psum_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid   <= tap_valid;
            s2_valid   <= s1_valid;
            psum_valid <= s2_valid & s2_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_first <= tap.first;
            s1_last  <= tap.last;
            s2_first <= s1_first;
            s2_last  <= s1_last;
            // Operands sign-extend to the partial-sum width
            prod     <= if_data * filt_data;
            if (s2_valid)
                acc <= sum_next;
            if (s2_valid && s2_last)
                psum_data <= sum_next;
        end
    end

endmodule

// File: design/operand_loader.sv
`include "pe_defs.svh"

module operand_loader (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               ifm_valid,
    output logic               ifm_ready,
    input  pe_pkg::in_word_t   ifm_word,
    input  logic               filt_valid,
    output logic               filt_ready,
    input  pe_pkg::in_word_t   filt_word,
    output logic               loaded,
    output pe_pkg::if_len_t    if_len,
    input  pe_pkg::if_addr_t   rd_if_addr,
    input  pe_pkg::filt_addr_t rd_filt_addr,
    input  logic               rd_en,
    output pe_pkg::data_t      if_data,
    output pe_pkg::data_t      filt_data
);
    import pe_pkg::*;

    data_t      if_mem [`PE_IF_DEPTH];
    data_t      filt_mem [`PE_FILT_DEPTH];
    if_addr_t   if_wptr;
    filt_addr_t filt_wptr;
    logic       ifm_open;
    logic       filt_open;
    logic       ifm_open_n;
    logic       filt_open_n;
    logic       ifm_fire;
    logic       filt_fire;

    assign ifm_ready   = ifm_open;
    assign filt_ready  = filt_open;
    assign ifm_fire    = ifm_valid & ifm_open;
    assign filt_fire   = filt_valid & filt_open;
    // Each stream closes on its own last word
    assign ifm_open_n  = ifm_open & ~(ifm_fire & ifm_word.last);
    assign filt_open_n = filt_open & ~(filt_fire & filt_word.last);

    always_ff @(posedge clk) begin
        if (rst) begin
            ifm_open  <= 1'b0;
            filt_open <= 1'b0;
            loaded    <= 1'b0;
            if_wptr   <= '0;
            filt_wptr <= '0;
            if_len    <= '0;
        end else if (start) begin
            ifm_open  <= 1'b1;
            filt_open <= 1'b1;
            loaded    <= 1'b0;
            if_wptr   <= '0;
            filt_wptr <= '0;
        end else begin
            ifm_open  <= ifm_open_n;
            filt_open <= filt_open_n;
            if (ifm_fire) begin
                if_wptr <= if_wptr + 1'b1;
                if (ifm_word.last)
                    if_len <= {1'b0, if_wptr} + 1'b1;
            end
            if (filt_fire)
                filt_wptr <= filt_wptr + 1'b1;
            // Both streams closed, whichever finished second
            if ((ifm_open | filt_open) & ~ifm_open_n & ~filt_open_n)
                loaded <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ifm_fire)
            if_mem[if_wptr] <= ifm_word.data;
        if (filt_fire)
            filt_mem[filt_wptr] <= filt_word.data;
        if (rd_en) begin
            if_data   <= if_mem[rd_if_addr];
            filt_data <= filt_mem[rd_filt_addr];
        end
    end

endmodule

// File: design/pe_config_regs.sv
`include "pe_defs.svh"

module pe_config_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [`PE_WB_AW-1:0] adr,
    input  logic [31:0]          dat_w,
    output logic [31:0]          dat_r,
    output logic                 ack,
    input  logic                 busy,
    input  logic                 out_fire,
    output logic                 start,
    output pe_pkg::run_cfg_t     cfg
);
    import pe_pkg::*;

    logic       access;
    logic       ran;
    logic       done;
    logic [7:0] out_count;

    // New access only when ack is low, so ack never spans two cycles
    assign access = cyc & stb & ~ack;

    // Done holds from the end of a run until the next start
    assign done = ran & ~busy & ~start;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack          <= 1'b0;
            start        <= 1'b0;
            ran          <= 1'b0;
            out_count    <= '0;
            cfg.filt_len <= filt_len_t'(1);
            cfg.stride   <= if_addr_t'(1);
        end else begin
            ack   <= access;
            start <= access & we & (adr == `PE_REG_CTRL) & dat_w[0] & ~busy;
            if (start) begin
                ran       <= 1'b1;
                out_count <= '0;
            end else if (out_fire) begin
                out_count <= out_count + 8'd1;
            end
            if (access && we) begin
                case (adr)
                    `PE_REG_FILT_LEN: cfg.filt_len <= dat_w[`PE_FILT_AW:0];
                    `PE_REG_STRIDE:   cfg.stride   <= dat_w[`PE_IF_AW-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data is captured with ack
    always_ff @(posedge clk) begin
        if (access && !we) begin
            case (adr)
                `PE_REG_FILT_LEN: dat_r <= 32'(cfg.filt_len);
                `PE_REG_STRIDE:   dat_r <= 32'(cfg.stride);
                `PE_REG_STATUS:   dat_r <= {16'h0, out_count, 6'h0, done, busy};
                default:          dat_r <= '0;
            endcase
        end
    end

endmodule

// File: design/pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// Datapath widths
`define PE_DATA_W 8
`define PE_ACC_W 24

// Scratchpad depths and address widths
`define PE_IF_DEPTH 32
`define PE_FILT_DEPTH 8
`define PE_IF_AW 5
`define PE_FILT_AW 3

// Wishbone word offsets
`define PE_WB_AW 2
`define PE_REG_CTRL `PE_WB_AW'd0
`define PE_REG_FILT_LEN `PE_WB_AW'd1
`define PE_REG_STRIDE `PE_WB_AW'd2
`define PE_REG_STATUS `PE_WB_AW'd3

`endif

// File: design/pe_pkg.sv
`include "pe_defs.svh"

package pe_pkg;

    typedef logic signed [`PE_DATA_W-1:0] data_t;
    // Partial sums wrap in two's complement
    typedef logic signed [`PE_ACC_W-1:0] acc_t;

    typedef logic [`PE_IF_AW-1:0] if_addr_t;
    typedef logic [`PE_FILT_AW-1:0] filt_addr_t;
    // Lengths need one extra bit to hold the full depth
    typedef logic [`PE_IF_AW:0] if_len_t;
    typedef logic [`PE_FILT_AW:0] filt_len_t;

    // Word on the ifmap and filter streams
    typedef struct packed {
        data_t data;
        logic  last;
    } in_word_t;

    // One tap from the address generator to the MAC
    typedef struct packed {
        if_addr_t   if_addr;
        filt_addr_t filt_addr;
        logic       first;
        logic       last;
    } tap_t;

    typedef struct packed {
        filt_len_t filt_len;
        if_addr_t  stride;
    } run_cfg_t;

    typedef enum logic [1:0] {IDLE, LOAD, RUN, DRAIN} run_state_t;

endpackage

// File: design/pe_top.sv
`include "pe_defs.svh"

module pe_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  logic [`PE_WB_AW-1:0] adr,
    input  logic [31:0]          dat_w,
    output logic [31:0]          dat_r,
    output logic                 ack,
    input  logic                 ifm_valid,
    output logic                 ifm_ready,
    input  pe_pkg::in_word_t     ifm_word,
    input  logic                 filt_valid,
    output logic                 filt_ready,
    input  pe_pkg::in_word_t     filt_word,
    output logic                 psum_valid,
    input  logic                 psum_ready,
    output pe_pkg::acc_t         psum_data
);
    import pe_pkg::*;

    run_cfg_t cfg;
    tap_t     tap;
    if_len_t  if_len;
    data_t    if_data;
    data_t    filt_data;
    logic     start;
    logic     busy;
    logic     loaded;
    logic     tap_valid;
    logic     stall;
    logic     rd_en;
    logic     out_fire;
    logic     out_drained;

    // Scratch read is the first MAC stage
    assign rd_en = tap_valid & ~stall;

    pe_config_regs i_pe_config_regs (
        .clk      (clk),
        .rst      (rst),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .busy     (busy),
        .out_fire (out_fire),
        .start    (start),
        .cfg      (cfg)
    );

    operand_loader i_operand_loader (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .ifm_valid    (ifm_valid),
        .ifm_ready    (ifm_ready),
        .ifm_word     (ifm_word),
        .filt_valid   (filt_valid),
        .filt_ready   (filt_ready),
        .filt_word    (filt_word),
        .loaded       (loaded),
        .if_len       (if_len),
        .rd_if_addr   (tap.if_addr),
        .rd_filt_addr (tap.filt_addr),
        .rd_en        (rd_en),
        .if_data      (if_data),
        .filt_data    (filt_data)
    );

    window_addr_gen i_window_addr_gen (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cfg         (cfg),
        .loaded      (loaded),
        .if_len      (if_len),
        .stall       (stall),
        .out_drained (out_drained),
        .tap_valid   (tap_valid),
        .tap         (tap),
        .busy        (busy)
    );

    mac_pipeline i_mac_pipeline (
        .clk         (clk),
        .rst         (rst),
        .tap_valid   (tap_valid),
        .tap         (tap),
        .if_data     (if_data),
        .filt_data   (filt_data),
        .psum_valid  (psum_valid),
        .psum_ready  (psum_ready),
        .psum_data   (psum_data),
        .stall       (stall),
        .out_fire    (out_fire),
        .out_drained (out_drained)
    );

endmodule

// File: design/window_addr_gen.sv
`include "pe_defs.svh"

module window_addr_gen (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  pe_pkg::run_cfg_t cfg,
    input  logic             loaded,
    input  pe_pkg::if_len_t  if_len,
    input  logic             stall,
    input  logic             out_drained,
    output logic             tap_valid,
    output pe_pkg::tap_t     tap,
    output logic             busy
);
    import pe_pkg::*;

    run_state_t           state;
    run_cfg_t             cfg_q;
    if_len_t              base;
    filt_addr_t           tap_k;
    logic [`PE_IF_AW+1:0] filt_ext;
    logic [`PE_IF_AW+1:0] len_ext;
    logic [`PE_IF_AW+1:0] base_next;
    logic [`PE_IF_AW+1:0] end_next;

    // Extra bits so base plus stride plus filter length cannot overflow
    assign filt_ext  = {{(`PE_IF_AW - `PE_FILT_AW + 1){1'b0}}, cfg_q.filt_len};
    assign len_ext   = {1'b0, if_len};
    assign base_next = {1'b0, base} + {2'b00, cfg_q.stride};
    assign end_next  = base_next + filt_ext;

    assign tap_valid     = (state == RUN);
    assign busy          = (state != IDLE);
    assign tap.if_addr   = base[`PE_IF_AW-1:0] + {{(`PE_IF_AW - `PE_FILT_AW){1'b0}}, tap_k};
    assign tap.filt_addr = tap_k;
    assign tap.first     = (tap_k == '0);
    assign tap.last      = ({1'b0, tap_k} == cfg_q.filt_len - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cfg_q <= '0;
            base  <= '0;
            tap_k <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Configuration is frozen for the whole run
                    if (start) begin
                        cfg_q <= cfg;
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    base  <= '0;
                    tap_k <= '0;
                    // Filter longer than the row gives no windows at all
                    if (loaded)
                        state <= (filt_ext > len_ext) ? IDLE : RUN;
                end
                RUN: begin
                    if (!stall) begin
                        if (tap.last) begin
                            tap_k <= '0;
                            base  <= base_next[`PE_IF_AW:0];
                            if (end_next > len_ext)
                                state <= DRAIN;
                        end else begin
                            tap_k <= tap_k + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (out_drained)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pe_tb -f sim.f \
    || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/Vpe_tb 2>&1)
echo "$sim_out"
grep -qF "Finished with no errors" <<< "$sim_out" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim.f
+incdir+design
design/pe_pkg.sv
design/pe_config_regs.sv
design/operand_loader.sv
design/window_addr_gen.sv
design/mac_pipeline.sv
design/pe_top.sv
bench/pe_tb.sv
